// File: stream_alu_pkg.sv
// ------------------------------------------------
// Shared definitions for the stream ALU
// Widths, opcode and control encodings, flag bits,
// command and response payload structs
// ------------------------------------------------

package stream_alu_pkg;

  // Operand, tag and flag widths
  localparam int DATA_W = 16;
  localparam int TAG_W  = 4;
  localparam int FLAG_W = 3;

  // Flag bit positions inside rsp_t.flags
  localparam int FLAG_CARRY = 0;
  localparam int FLAG_ZERO  = 1;
  localparam int FLAG_ERR   = 2;

  // Command opcodes, codes 6 and 7 are illegal
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    MAX = 3'd5
  } op_e;

  // Execute unit select
  typedef enum logic [1:0] {
    SEL_ARITH = 2'd0,
    SEL_LOGIC = 2'd1,
    SEL_MAX   = 2'd2
  } alu_sel_e;

  // Bitwise function for the logic unit
  typedef enum logic [1:0] {
    FN_AND = 2'd0,
    FN_OR  = 2'd1,
    FN_XOR = 2'd2
  } logic_fn_e;

  // Command beat, 39 bits
  typedef struct packed {
    op_e               op;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } cmd_t;

  // Response beat, 23 bits
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] result;
    logic [FLAG_W-1:0] flags;
  } rsp_t;

endpackage

// File: axi_fifo_short.sv
// ------------------------------------------------
// Short valid/ready FIFO, 2**DEPTH_LOG2 entries
// Shift-register storage with a read pointer,
// space and occupied counters, synchronous clear
// ------------------------------------------------

module axi_fifo_short #(
  parameter type T          = stream_alu_pkg::cmd_t,
  parameter int  DEPTH_LOG2 = 5
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_clear,
  input  T                    i_tdata,
  input  logic                i_tvalid,
  output logic                i_tready,
  output T                    o_tdata,
  output logic                o_tvalid,
  input  logic                o_tready,
  output logic [DEPTH_LOG2:0] o_space,
  output logic [DEPTH_LOG2:0] o_occupied
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;
  localparam int CNT_W = DEPTH_LOG2 + 1;

  T                      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic                  full;
  logic                  empty;
  logic                  write;
  logic                  read;

  assign write    = i_tvalid & i_tready;
  assign read     = o_tvalid & o_tready;
  assign i_tready = ~full;
  assign o_tvalid = ~empty;

  // Oldest entry sits at the read pointer
  assign o_tdata = mem[rd_ptr];

  // New data always enters at slot 0 and pushes older entries up
  always_ff @(posedge clk) begin
    if (write) begin
      mem[0] <= i_tdata;
      for (int i = 1; i < DEPTH; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  // Pointer and flags move only when exactly one side transfers
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      rd_ptr <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
    end else if (read && !write) begin
      full <= 1'b0;
      if (rd_ptr == '0) begin
        empty <= 1'b1;
      end else begin
        rd_ptr <= rd_ptr - 1'b1;
      end
    end else if (write && !read) begin
      empty <= 1'b0;
      if (!empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Last free slot about to be taken
      if (rd_ptr == DEPTH_LOG2'(DEPTH - 2)) begin
        full <= 1'b1;
      end
    end
  end

  // Level counters
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_space    <= CNT_W'(DEPTH);
      o_occupied <= '0;
    end else if (read && !write) begin
      o_space    <= o_space + 1'b1;
      o_occupied <= o_occupied - 1'b1;
    end else if (write && !read) begin
      o_space    <= o_space - 1'b1;
      o_occupied <= o_occupied + 1'b1;
    end
  end

  // Flags and counters must agree, or a write lands on a full FIFO
  a_no_overflow : assert property (@(posedge clk) disable iff (reset)
    write && !read |-> o_occupied < CNT_W'(DEPTH));

  // Same for a read from an empty FIFO
  a_no_underflow : assert property (@(posedge clk) disable iff (reset)
    read && !write |-> o_occupied != '0);

endmodule

// File: cmd_decode.sv
// ------------------------------------------------
// Decode stage of the stream ALU
// Maps the opcode to execute controls, flags
// illegal opcodes, one register slice
// ------------------------------------------------

module cmd_decode (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_clear,
  input  stream_alu_pkg::op_e                 i_op,
  input  logic [stream_alu_pkg::TAG_W-1:0]    i_tag,
  input  logic [stream_alu_pkg::DATA_W-1:0]   i_a,
  input  logic [stream_alu_pkg::DATA_W-1:0]   i_b,
  input  logic                                i_valid,
  input  logic                                i_ready,
  output logic                                o_ready,
  output stream_alu_pkg::alu_sel_e            o_sel,
  output stream_alu_pkg::logic_fn_e           o_fn,
  output logic                                o_sub,
  output logic                                o_err,
  output logic [stream_alu_pkg::TAG_W-1:0]    o_tag,
  output logic [stream_alu_pkg::DATA_W-1:0]   o_a,
  output logic [stream_alu_pkg::DATA_W-1:0]   o_b,
  output logic                                o_valid
);

  import stream_alu_pkg::*;

  alu_sel_e  dec_sel;
  logic_fn_e dec_fn;
  logic      dec_sub;
  logic      dec_err;

  // Take a beat when the slot is free or being drained
  assign o_ready = ~o_valid | i_ready;

  always_comb begin
    dec_sel = SEL_ARITH;
    dec_fn  = FN_AND;
    dec_sub = 1'b0;
    dec_err = 1'b0;
    case (i_op)
      ADD: dec_sel = SEL_ARITH;
      SUB: dec_sub = 1'b1;
      AND: begin
        dec_sel = SEL_LOGIC;
        dec_fn  = FN_AND;
      end
      OR: begin
        dec_sel = SEL_LOGIC;
        dec_fn  = FN_OR;
      end
      XOR: begin
        dec_sel = SEL_LOGIC;
        dec_fn  = FN_XOR;
      end
      MAX:     dec_sel = SEL_MAX;
      default: dec_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      o_sel <= dec_sel;
      o_fn  <= dec_fn;
      o_sub <= dec_sub;
      o_err <= dec_err;
      o_tag <= i_tag;
      o_a   <= i_a;
      o_b   <= i_b;
    end
  end

  // A command waiting at the input holds until decode takes it
  a_hold_stable : assert property (@(posedge clk) disable iff (reset)
    i_valid && !o_ready && !i_clear |=> i_valid && $stable({i_op, i_tag, i_a, i_b}));

endmodule

// File: alu_execute.sv
// ------------------------------------------------
// Execute stage of the stream ALU
// Add/sub with carry, logic ops, unsigned max,
// one register slice
// ------------------------------------------------

module alu_execute (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_clear,
  input  stream_alu_pkg::alu_sel_e            i_sel,
  input  stream_alu_pkg::logic_fn_e           i_fn,
  input  logic                                i_sub,
  input  logic                                i_err,
  input  logic [stream_alu_pkg::TAG_W-1:0]    i_tag,
  input  logic [stream_alu_pkg::DATA_W-1:0]   i_a,
  input  logic [stream_alu_pkg::DATA_W-1:0]   i_b,
  input  logic                                i_valid,
  input  logic                                i_ready,
  output logic                                o_ready,
  output logic [stream_alu_pkg::DATA_W-1:0]   o_result,
  output logic                                o_carry,
  output logic                                o_err,
  output logic [stream_alu_pkg::TAG_W-1:0]    o_tag,
  output logic                                o_valid
);

  import stream_alu_pkg::*;

  logic [DATA_W:0]   arith;
  logic [DATA_W-1:0] logic_res;
  logic [DATA_W-1:0] max_res;
  logic [DATA_W-1:0] result;
  logic              carry;

  assign o_ready = ~o_valid | i_ready;

  // Top bit is carry out on add, borrow on subtract
  assign arith = i_sub ? ({1'b0, i_a} - {1'b0, i_b}) : ({1'b0, i_a} + {1'b0, i_b});

  always_comb begin
    case (i_fn)
      FN_OR:   logic_res = i_a | i_b;
      FN_XOR:  logic_res = i_a ^ i_b;
      default: logic_res = i_a & i_b;
    endcase
  end

  // Unsigned compare
  assign max_res = (i_a > i_b) ? i_a : i_b;

  always_comb begin
    result = '0;
    carry  = 1'b0;
    if (!i_err) begin
      case (i_sel)
        SEL_ARITH: begin
          result = arith[DATA_W-1:0];
          carry  = arith[DATA_W];
        end
        SEL_LOGIC: result = logic_res;
        SEL_MAX:   result = max_res;
        default:   result = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      o_result <= result;
      o_carry  <= carry;
      o_err    <= i_err;
      o_tag    <= i_tag;
    end
  end

  // Subtract borrow is set exactly when b exceeds a
  a_sub_borrow : assert property (@(posedge clk) disable iff (reset || i_clear)
    i_valid && o_ready && !i_err && i_sel == SEL_ARITH && i_sub
    |=> o_carry == ($past(i_a) < $past(i_b)));

endmodule

// File: result_format.sv
// ------------------------------------------------
// Result stage of the stream ALU
// Builds carry, zero and error flags and packs
// the response, one register slice
// ------------------------------------------------

module result_format (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_clear,
  input  logic [stream_alu_pkg::DATA_W-1:0]   i_result,
  input  logic                                i_carry,
  input  logic                                i_err,
  input  logic [stream_alu_pkg::TAG_W-1:0]    i_tag,
  input  logic                                i_valid,
  input  logic                                i_ready,
  output logic                                o_ready,
  output stream_alu_pkg::rsp_t                o_rsp,
  output logic                                o_valid
);

  import stream_alu_pkg::*;

  logic [FLAG_W-1:0] flags;

  assign o_ready = ~o_valid | i_ready;

  always_comb begin
    flags             = '0;
    flags[FLAG_CARRY] = i_carry;
    flags[FLAG_ZERO]  = (i_result == '0);
    flags[FLAG_ERR]   = i_err;
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      o_rsp.tag    <= i_tag;
      o_rsp.result <= i_result;
      o_rsp.flags  <= flags;
    end
  end

  // Execute zeroes the result of an illegal opcode
  a_err_zero : assert property (@(posedge clk) disable iff (reset || i_clear)
    o_valid && o_rsp.flags[FLAG_ERR] |-> o_rsp.result == '0 && o_rsp.flags[FLAG_ZERO]);

endmodule

// File: stream_alu_top.sv
// ------------------------------------------------
// Stream ALU top level
// Input FIFO, decode, execute, result, output FIFO
// ------------------------------------------------

module stream_alu_top #(
  parameter int FIFO_DEPTH_LOG2 = 5
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_clear,
  input  stream_alu_pkg::op_e                 i_cmd_op,
  input  logic [stream_alu_pkg::TAG_W-1:0]    i_cmd_tag,
  input  logic [stream_alu_pkg::DATA_W-1:0]   i_cmd_a,
  input  logic [stream_alu_pkg::DATA_W-1:0]   i_cmd_b,
  input  logic                                i_cmd_valid,
  input  logic                                i_rsp_ready,
  output logic                                o_cmd_ready,
  output logic [stream_alu_pkg::TAG_W-1:0]    o_rsp_tag,
  output logic [stream_alu_pkg::DATA_W-1:0]   o_rsp_result,
  output logic [stream_alu_pkg::FLAG_W-1:0]   o_rsp_flags,
  output logic                                o_rsp_valid,
  output logic [FIFO_DEPTH_LOG2:0]            o_in_space,
  output logic [FIFO_DEPTH_LOG2:0]            o_out_occupied
);

  import stream_alu_pkg::*;

  cmd_t              in_cmd;
  cmd_t              fifo_cmd;
  logic              fifo_cmd_valid;
  logic              dec_ready;
  alu_sel_e          dec_sel;
  logic_fn_e         dec_fn;
  logic              dec_sub;
  logic              dec_err;
  logic [TAG_W-1:0]  dec_tag;
  logic [DATA_W-1:0] dec_a;
  logic [DATA_W-1:0] dec_b;
  logic              dec_valid;
  logic              exe_ready;
  logic [DATA_W-1:0] exe_result;
  logic              exe_carry;
  logic              exe_err;
  logic [TAG_W-1:0]  exe_tag;
  logic              exe_valid;
  logic              fmt_ready;
  rsp_t              fmt_rsp;
  logic              fmt_valid;
  logic              out_ready;
  rsp_t              out_rsp;

  assign in_cmd = '{op: i_cmd_op, tag: i_cmd_tag, a: i_cmd_a, b: i_cmd_b};

  axi_fifo_short #(.T(cmd_t), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_in_fifo (
    .clk, .reset, .i_clear,
    .i_tdata(in_cmd), .i_tvalid(i_cmd_valid), .i_tready(o_cmd_ready),
    .o_tdata(fifo_cmd), .o_tvalid(fifo_cmd_valid), .o_tready(dec_ready),
    .o_space(o_in_space), .o_occupied()
  );

  cmd_decode u_cmd_decode (
    .clk, .reset, .i_clear,
    .i_op(fifo_cmd.op), .i_tag(fifo_cmd.tag), .i_a(fifo_cmd.a), .i_b(fifo_cmd.b),
    .i_valid(fifo_cmd_valid), .i_ready(exe_ready), .o_ready(dec_ready),
    .o_sel(dec_sel), .o_fn(dec_fn), .o_sub(dec_sub), .o_err(dec_err),
    .o_tag(dec_tag), .o_a(dec_a), .o_b(dec_b), .o_valid(dec_valid)
  );

  alu_execute u_alu_execute (
    .clk, .reset, .i_clear,
    .i_sel(dec_sel), .i_fn(dec_fn), .i_sub(dec_sub), .i_err(dec_err),
    .i_tag(dec_tag), .i_a(dec_a), .i_b(dec_b),
    .i_valid(dec_valid), .i_ready(fmt_ready), .o_ready(exe_ready),
    .o_result(exe_result), .o_carry(exe_carry), .o_err(exe_err),
    .o_tag(exe_tag), .o_valid(exe_valid)
  );

  result_format u_result_format (
    .clk, .reset, .i_clear,
    .i_result(exe_result), .i_carry(exe_carry), .i_err(exe_err), .i_tag(exe_tag),
    .i_valid(exe_valid), .i_ready(out_ready), .o_ready(fmt_ready),
    .o_rsp(fmt_rsp), .o_valid(fmt_valid)
  );

  axi_fifo_short #(.T(rsp_t), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_out_fifo (
    .clk, .reset, .i_clear,
    .i_tdata(fmt_rsp), .i_tvalid(fmt_valid), .i_tready(out_ready),
    .o_tdata(out_rsp), .o_tvalid(o_rsp_valid), .o_tready(i_rsp_ready),
    .o_space(), .o_occupied(o_out_occupied)
  );

  // Response fields out as loose ports
  assign o_rsp_tag    = out_rsp.tag;
  assign o_rsp_result = out_rsp.result;
  assign o_rsp_flags  = out_rsp.flags;

endmodule

// File: tb_stream_alu.sv
// --------------------------------------------------
// Testbench for the stream ALU
// Random commands from a fixed seed, reference model,
// back-pressure, fill/stall and clear checks
// --------------------------------------------------

module tb_stream_alu;

  timeunit 1ns;
  timeprecision 1ps;

  import stream_alu_pkg::*;

  localparam int DEPTH_LOG2  = 5;
  localparam int DEPTH       = 2 ** DEPTH_LOG2;
  localparam int SEED        = 47452;
  localparam int N_FREE      = 300;
  localparam int N_BP        = 300;
  localparam int N_FILL      = 2 * DEPTH + 3;
  localparam int N_CLR       = 40;
  localparam int N_FRESH     = 20;
  localparam int CYCLE_LIMIT = (N_FREE + N_BP + N_FILL + N_CLR + N_FRESH) * 4 + 1000;
  localparam logic [DEPTH_LOG2:0] FULL_LEVEL = (DEPTH_LOG2 + 1)'(DEPTH);

  // Response ready modes for run_commands
  localparam int RSP_FREE = 0;
  localparam int RSP_RAND = 1;
  localparam int RSP_HOLD = 2;

  logic                clk;
  logic                reset;
  logic                i_clear;
  op_e                 i_cmd_op;
  logic [TAG_W-1:0]    i_cmd_tag;
  logic [DATA_W-1:0]   i_cmd_a;
  logic [DATA_W-1:0]   i_cmd_b;
  logic                i_cmd_valid;
  logic                i_rsp_ready;
  logic                o_cmd_ready;
  logic [TAG_W-1:0]    o_rsp_tag;
  logic [DATA_W-1:0]   o_rsp_result;
  logic [FLAG_W-1:0]   o_rsp_flags;
  logic                o_rsp_valid;
  logic [DEPTH_LOG2:0] o_in_space;
  logic [DEPTH_LOG2:0] o_out_occupied;

  rsp_t  exp_q[$];
  int    cycles;
  bit    took_cmd;
  string test_name;

  stream_alu_top #(.FIFO_DEPTH_LOG2(DEPTH_LOG2)) u_stream_alu_top (.*);

  always #5 clk = ~clk;

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at cycle %0d", cycles);
  endtask

  task automatic check_rsp(string name, rsp_t exp, logic [TAG_W-1:0] tag,
                           logic [DATA_W-1:0] result, logic [FLAG_W-1:0] flags);
    if (tag !== exp.tag || result !== exp.result || flags !== exp.flags) begin
      $display(
        "Mismatch in %s: expected tag %h result %h flags %b, actual tag %h result %h flags %b",
        name, exp.tag, exp.result, exp.flags, tag, result, flags);
      stop_run();
    end
  endtask

  task automatic check_level(string name, logic [DEPTH_LOG2:0] exp, logic [DEPTH_LOG2:0] act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected level %0d, actual level %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected bit %b, actual bit %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      $display("Mismatch in %s: expected count %0d, actual count %0d", name, exp, act);
      stop_run();
    end
  endtask

  // Reference model of one command
  function automatic rsp_t expected_rsp(logic [2:0] op, logic [TAG_W-1:0] tag,
                                        logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
    rsp_t r;
    r     = '0;
    r.tag = tag;
    case (op)
      3'd0: begin
        r.result            = a + b;
        r.flags[FLAG_CARRY] = (int'(a) + int'(b)) > 65535;
      end
      3'd1: begin
        r.result            = a - b;
        r.flags[FLAG_CARRY] = a < b;
      end
      3'd2:    r.result = a & b;
      3'd3:    r.result = a | b;
      3'd4:    r.result = a ^ b;
      3'd5:    r.result = (a >= b) ? a : b;
      default: r.flags[FLAG_ERR] = 1'b1;
    endcase
    r.flags[FLAG_ZERO] = (r.result == '0);
    return r;
  endfunction

  // Advance one clock edge, then sample both handshakes and check any response
  task automatic step();
    rsp_t exp;
    @(posedge clk);
    cycles++;
    took_cmd = i_cmd_valid && o_cmd_ready;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout in %s: run exceeded %0d cycles", test_name, CYCLE_LIMIT);
      stop_run();
    end else if (o_rsp_valid && i_rsp_ready && exp_q.size() == 0) begin
      $display("Unexpected response with tag %h in %s, no command outstanding",
               o_rsp_tag, test_name);
      stop_run();
    end else begin
      if (took_cmd) begin
        exp_q.push_back(expected_rsp(i_cmd_op, i_cmd_tag, i_cmd_a, i_cmd_b));
      end
      if (o_rsp_valid && i_rsp_ready) begin
        exp = exp_q.pop_front();
        check_rsp(test_name, exp, o_rsp_tag, o_rsp_result, o_rsp_flags);
      end
    end
  endtask

  task automatic drive_random_cmd();
    logic [DATA_W-1:0] a;
    a = DATA_W'($urandom());
    i_cmd_op  <= op_e'(3'($urandom_range(0, 7)));
    i_cmd_tag <= TAG_W'($urandom());
    i_cmd_a   <= a;
    // Equal operands now and then give zero results and max ties
    if ($urandom_range(0, 7) == 0) begin
      i_cmd_b <= a;
    end else begin
      i_cmd_b <= DATA_W'($urandom());
    end
    i_cmd_valid <= 1'b1;
  endtask

  task automatic run_commands(int n, bit gaps, int rsp_mode);
    int sent;
    bit pending;
    sent    = 0;
    pending = 1'b0;
    while (sent < n) begin
      if (!pending && (!gaps || $urandom_range(0, 3) != 0)) begin
        drive_random_cmd();
        pending = 1'b1;
      end else if (!pending) begin
        i_cmd_valid <= 1'b0;
      end
      case (rsp_mode)
        RSP_RAND: i_rsp_ready <= 1'($urandom_range(0, 1));
        RSP_HOLD: i_rsp_ready <= 1'b0;
        default:  i_rsp_ready <= 1'b1;
      endcase
      step();
      if (took_cmd) begin
        sent++;
        pending = 1'b0;
      end
    end
    i_cmd_valid <= 1'b0;
  endtask

  task automatic drain();
    i_cmd_valid <= 1'b0;
    i_rsp_ready <= 1'b1;
    while (exp_q.size() != 0) begin
      step();
    end
    // A few idle cycles catch duplicated responses
    repeat (8) step();
    check_level(test_name, '0, o_out_occupied);
  endtask

  initial begin
    int accepted;
    bit stalled;
    void'($urandom(SEED));
    clk         = 1'b0;
    reset       = 1'b1;
    i_clear     = 1'b0;
    i_cmd_op    = ADD;
    i_cmd_tag   = '0;
    i_cmd_a     = '0;
    i_cmd_b     = '0;
    i_cmd_valid = 1'b0;
    i_rsp_ready = 1'b0;
    cycles      = 0;
    took_cmd    = 1'b0;
    test_name   = "idle_levels";
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    step();
    check_level(test_name, FULL_LEVEL, o_in_space);
    check_level(test_name, '0, o_out_occupied);
    check_bit(test_name, 1'b0, o_rsp_valid);
    check_bit(test_name, 1'b1, o_cmd_ready);

    test_name = "free_flow";
    run_commands(N_FREE, 1'b0, RSP_FREE);
    drain();

    test_name = "back_pressure";
    run_commands(N_BP, 1'b1, RSP_RAND);
    drain();

    // Output FIFO, three stages and input FIFO all fill up
    test_name = "fill_stall";
    accepted  = 0;
    stalled   = 1'b0;
    i_rsp_ready <= 1'b0;
    drive_random_cmd();
    while (!stalled) begin
      step();
      if (took_cmd) begin
        accepted++;
        drive_random_cmd();
      end else if (!o_cmd_ready) begin
        stalled = 1'b1;
      end
    end
    i_cmd_valid <= 1'b0;
    check_count(test_name, N_FILL, accepted);
    check_level(test_name, '0, o_in_space);
    check_level(test_name, FULL_LEVEL, o_out_occupied);
    drain();

    test_name = "clear";
    run_commands(N_CLR, 1'b0, RSP_HOLD);
    repeat (6) step();
    check_bit(test_name, 1'b1, o_rsp_valid);
    i_clear <= 1'b1;
    step();
    i_clear <= 1'b0;
    step();
    exp_q.delete();
    check_level(test_name, FULL_LEVEL, o_in_space);
    check_level(test_name, '0, o_out_occupied);
    check_bit(test_name, 1'b0, o_rsp_valid);
    check_bit(test_name, 1'b1, o_cmd_ready);

    test_name = "after_clear";
    run_commands(N_FRESH, 1'b0, RSP_FREE);
    drain();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: compile.f
stream_alu_pkg.sv
axi_fifo_short.sv
cmd_decode.sv
alu_execute.sv
result_format.sv
stream_alu_top.sv
tb_stream_alu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the stream ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_stream_alu \
  -f compile.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
